//--- src.f
mem_pkg.sv
mem_op_if.sv
byte_lane_if.sv
mem_arbiter.sv
byte_sequencer.sv
word_assembler.sv
mem_ctrl_top.sv
tb_mem_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
if [ $? -ne 0 ]; then
    echo "could not clean obj_dir"
    exit 1
fi

verilator --binary --assert --timescale 1ns/1ps --top-module tb_mem_ctrl \
    -f src.f -o tb_mem_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb_mem_ctrl.sv
// memory controller testbench
`timescale 1ns/1ps

module tb_mem_ctrl;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int AW = mem_pkg::ADDR_W;
    localparam int DW = mem_pkg::XLEN;

    logic                  clk;
    logic                  rst_i;
    logic                  fetch_req_i;
    logic [AW-1:0]         fetch_addr_i;
    logic                  fetch_busy_o;
    logic [DW-1:0]         fetch_rdata_o;
    logic                  fetch_valid_o;
    logic                  data_req_i;
    logic                  data_we_i;
    logic [AW-1:0]         data_addr_i;
    logic [DW-1:0]         data_wdata_i;
    mem_pkg::access_size_e data_size_i;
    logic                  data_busy_o;
    logic [DW-1:0]         data_rdata_o;
    logic                  data_valid_o;
    logic [AW-1:0]         ram_addr_o;
    logic [7:0]            ram_wdata_o;
    logic                  ram_we_o;
    logic [7:0]            ram_rdata_i = 8'h00;

    // byte ram and the reference copy of it
    logic [7:0]  ram_mem [0:255];
    logic [7:0]  ref_mem [0:255];

    // {compare flag, expected word} per outstanding access
    logic [DW:0] fetch_exp_q [$];
    logic [DW:0] data_exp_q [$];

    int unsigned cycle_no = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_start = 0;

    mem_ctrl_top #(.ADDR_W(AW)) i_mem_ctrl_top (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_busy_o  (fetch_busy_o),
        .fetch_rdata_o (fetch_rdata_o),
        .fetch_valid_o (fetch_valid_o),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_size_i   (data_size_i),
        .data_busy_o   (data_busy_o),
        .data_rdata_o  (data_rdata_o),
        .data_valid_o  (data_valid_o),
        .ram_addr_o    (ram_addr_o),
        .ram_wdata_o   (ram_wdata_o),
        .ram_we_o      (ram_we_o),
        .ram_rdata_i   (ram_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
    end

    // synchronous ram, read data one cycle after the address
    always @(posedge clk) begin
        if (ram_we_o === 1'b1) begin
            ram_mem[ram_addr_o[7:0]] <= ram_wdata_o;
        end
        ram_rdata_i <= ram_mem[ram_addr_o[7:0]];
    end

    // little-endian load from the reference copy, zero-extended
    function automatic logic [DW-1:0] expected_load(logic [AW-1:0] addr,
                                                    mem_pkg::access_size_e size);
        logic [DW-1:0] result;
        logic [7:0]    idx;
        result = '0;
        for (int k = 0; k < int'(mem_pkg::byte_count(size)); k++) begin
            idx = addr[7:0] + 8'(k);
            result[8*k +: 8] = ref_mem[idx];
        end
        return result;
    endfunction

    function automatic void mirror_store(logic [AW-1:0] addr, logic [DW-1:0] wdata,
                                         mem_pkg::access_size_e size);
        logic [7:0] idx;
        for (int k = 0; k < int'(mem_pkg::byte_count(size)); k++) begin
            idx = addr[7:0] + 8'(k);
            ref_mem[idx] = wdata[8*k +: 8];
        end
    endfunction

    task automatic report_timeout(string what);
        $display("timeout: %s did not arrive within %0d cycles", what, TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic begin_test();
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic end_test(string name);
        if (errors == test_err_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_err_start);
        end
    endtask

    // one data port access, returns acceptance-to-valid latency
    task automatic data_access(input logic we, input logic [AW-1:0] addr,
                               input logic [DW-1:0] wdata,
                               input mem_pkg::access_size_e size,
                               output int latency, output int unsigned done_cycle);
        int   cycles;
        int   accept_at;
        logic got;
        if (we) begin
            mirror_store(addr, wdata, size);
            data_exp_q.push_back({1'b0, {DW{1'b0}}});
        end else begin
            data_exp_q.push_back({1'b1, expected_load(addr, size)});
        end
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_addr_i  = addr;
        data_wdata_i = wdata;
        data_size_i  = size;
        cycles    = 0;
        accept_at = 0;
        got       = 1'b0;
        while (!got && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            if (accept_at == 0 && data_busy_o === 1'b1) begin
                accept_at = cycles;
            end
            if (data_valid_o === 1'b1) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            report_timeout("data_valid_o");
        end else begin
            latency    = cycles - accept_at;
            done_cycle = cycle_no;
            data_req_i = 1'b0;
            data_we_i  = 1'b0;
            // next request goes up in the cycle after valid
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fetch_access(input logic [AW-1:0] addr, output int latency,
                                output int unsigned done_cycle);
        int   cycles;
        int   accept_at;
        logic got;
        fetch_exp_q.push_back({1'b1, expected_load(addr, mem_pkg::SIZE_WORD)});
        fetch_req_i  = 1'b1;
        fetch_addr_i = addr;
        cycles    = 0;
        accept_at = 0;
        got       = 1'b0;
        while (!got && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            if (accept_at == 0 && fetch_busy_o === 1'b1) begin
                accept_at = cycles;
            end
            if (fetch_valid_o === 1'b1) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            report_timeout("fetch_valid_o");
        end else begin
            latency     = cycles - accept_at;
            done_cycle  = cycle_no;
            fetch_req_i = 1'b0;
            @(posedge clk);
            #1;
        end
    endtask

    // compare every valid pulse with the value queued for its port
    always begin
        logic [DW:0] item;
        @(posedge clk);
        #1;
        if (fetch_valid_o === 1'b1) begin
            if (fetch_exp_q.size() == 0) begin
                errors++;
                $display("fetch port gave a valid pulse with no request outstanding");
            end else begin
                item = fetch_exp_q.pop_front();
                checks++;
                if (fetch_rdata_o !== item[DW-1:0]) begin
                    errors++;
                    $display("FAILED fetch_rdata_o: got %h expected %h",
                             fetch_rdata_o, item[DW-1:0]);
                end
            end
        end
        if (data_valid_o === 1'b1) begin
            if (data_exp_q.size() == 0) begin
                errors++;
                $display("data port gave a valid pulse with no request outstanding");
            end else begin
                item = data_exp_q.pop_front();
                checks++;
                if (item[DW] && data_rdata_o !== item[DW-1:0]) begin
                    errors++;
                    $display("FAILED data_rdata_o: got %h expected %h",
                             data_rdata_o, item[DW-1:0]);
                end
            end
        end
    end

    initial begin
        logic [AW-1:0]         addr;
        logic [DW-1:0]         wdata;
        mem_pkg::access_size_e size;
        int                    lat_d;
        int                    lat_f;
        int unsigned           done_d;
        int unsigned           done_f;
        logic [AW-1:0]         bb_data_addr [0:11];
        mem_pkg::access_size_e bb_data_size [0:11];
        logic [AW-1:0]         bb_fetch_addr [0:11];

        void'($urandom(78));
        rst_i        = 1'b1;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_size_i  = mem_pkg::SIZE_BYTE;
        for (int i = 0; i < 256; i++) begin
            ram_mem[i] <= 8'((i * 29) ^ 108);
            ref_mem[i] = 8'((i * 29) ^ 108);
        end

        // 1: outputs quiet during and right after reset
        begin_test();
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            #1;
            if (c == 2) begin
                rst_i = 1'b0;
            end
            checks++;
            if ({fetch_valid_o, data_valid_o, fetch_busy_o, data_busy_o, ram_we_o} !== 5'b0) begin
                errors++;
                $display({"FAILED fetch_valid_o/data_valid_o/fetch_busy_o/data_busy_o/",
                          "ram_we_o: got %h expected %h"},
                         {fetch_valid_o, data_valid_o, fetch_busy_o, data_busy_o, ram_we_o},
                         5'h00);
            end
            if ({fetch_rdata_o, data_rdata_o} !== '0) begin
                errors++;
                $display("FAILED fetch_rdata_o/data_rdata_o: got %h expected %h",
                         {fetch_rdata_o, data_rdata_o}, 64'h0);
            end
        end
        end_test("reset");

        // 2: stores then loads of the same size and address
        begin_test();
        for (int i = 0; i < 12; i++) begin
            addr  = $urandom;
            wdata = $urandom;
            size  = mem_pkg::access_size_e'(2'($urandom_range(2, 0)));
            data_access(1'b1, addr, wdata, size, lat_d, done_d);
            data_access(1'b0, addr, '0, size, lat_d, done_d);
        end
        end_test("store and load");

        // 3: fetch from the fill pattern and from stored words
        begin_test();
        for (int i = 0; i < 4; i++) begin
            addr = $urandom;
            fetch_access(addr, lat_f, done_f);
            addr  = $urandom;
            wdata = $urandom;
            data_access(1'b1, addr, wdata, mem_pkg::SIZE_WORD, lat_d, done_d);
            fetch_access(addr, lat_f, done_f);
        end
        end_test("fetch");

        // 4: idle pipeline latency
        begin_test();
        addr = $urandom;
        fetch_access(addr, lat_f, done_f);
        data_access(1'b0, addr, '0, mem_pkg::SIZE_WORD, lat_d, done_d);
        checks++;
        if (lat_f != 6 || lat_d != 6) begin
            errors++;
            $display("FAILED word read latency: got %h and %h expected %h", lat_f, lat_d, 6);
        end
        data_access(1'b1, $urandom, $urandom, mem_pkg::SIZE_BYTE, lat_d, done_d);
        checks++;
        if (lat_d != 2) begin
            errors++;
            $display("FAILED byte write latency: got %h expected %h", lat_d, 2);
        end
        end_test("idle latency");

        // 5: both ports in the same cycle, data port first
        begin_test();
        for (int i = 0; i < 4; i++) begin
            addr = $urandom;
            size = mem_pkg::access_size_e'(2'($urandom_range(2, 0)));
            fork
                data_access(1'b0, addr, '0, size, lat_d, done_d);
                fetch_access(addr + 32'd64, lat_f, done_f);
            join
            checks++;
            if (!(done_d < done_f)) begin
                errors++;
                $display("data port valid did not come before fetch port valid");
            end
        end
        end_test("collision");

        // 6: back-to-back loads and fetches on both ports
        begin_test();
        for (int i = 0; i < 12; i++) begin
            bb_data_addr[i]  = $urandom;
            bb_data_size[i]  = mem_pkg::access_size_e'(2'($urandom_range(2, 0)));
            bb_fetch_addr[i] = $urandom;
        end
        fork
            for (int i = 0; i < 12; i++) begin
                data_access(1'b0, bb_data_addr[i], '0, bb_data_size[i], lat_d, done_d);
            end
            for (int i = 0; i < 12; i++) begin
                fetch_access(bb_fetch_addr[i], lat_f, done_f);
            end
        join
        // quiet tail, a stray valid pulse lands on an empty queue
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        end_test("back-to-back");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- mem_ctrl_top.sv
// memory controller top level
`timescale 1ns/1ps

module mem_ctrl_top #(
    parameter int ADDR_W = mem_pkg::ADDR_W
) (
    input  logic                      clk,
    input  logic                      rst_i,

    input  logic                      fetch_req_i,
    input  logic [ADDR_W-1:0]         fetch_addr_i,
    output logic                      fetch_busy_o,
    output logic [mem_pkg::XLEN-1:0]  fetch_rdata_o,
    output logic                      fetch_valid_o,

    input  logic                      data_req_i,
    input  logic                      data_we_i,
    input  logic [ADDR_W-1:0]         data_addr_i,
    input  logic [mem_pkg::XLEN-1:0]  data_wdata_i,
    input  mem_pkg::access_size_e     data_size_i,
    output logic                      data_busy_o,
    output logic [mem_pkg::XLEN-1:0]  data_rdata_o,
    output logic                      data_valid_o,

    output logic [ADDR_W-1:0]         ram_addr_o,
    output logic [7:0]                ram_wdata_o,
    output logic                      ram_we_o,
    input  logic [7:0]                ram_rdata_i
);

    logic           done;
    mem_pkg::port_e done_port;

    mem_op_if #(.ADDR_W(ADDR_W)) mem_op ();
    byte_lane_if                 byte_lane ();

    mem_arbiter #(.ADDR_W(ADDR_W)) i_mem_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_size_i  (data_size_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .data_busy_o  (data_busy_o),
        .fetch_busy_o (fetch_busy_o),
        .done_port_i  (done_port),
        .done_i       (done),
        .op           (mem_op.arb)
    );

    byte_sequencer #(.ADDR_W(ADDR_W)) i_byte_sequencer (
        .clk         (clk),
        .rst_i       (rst_i),
        .op          (mem_op.seq),
        .lane        (byte_lane.seq),
        .ram_addr_o  (ram_addr_o),
        .ram_wdata_o (ram_wdata_o),
        .ram_we_o    (ram_we_o)
    );

    word_assembler i_word_assembler (
        .clk           (clk),
        .rst_i         (rst_i),
        .lane          (byte_lane.asm),
        .ram_rdata_i   (ram_rdata_i),
        .fetch_rdata_o (fetch_rdata_o),
        .fetch_valid_o (fetch_valid_o),
        .data_rdata_o  (data_rdata_o),
        .data_valid_o  (data_valid_o),
        .done_o        (done),
        .done_port_o   (done_port)
    );

endmodule

//--- word_assembler.sv
// read word assembly and completion
`timescale 1ns/1ps

module word_assembler (
    input  logic                     clk,
    input  logic                     rst_i,

    byte_lane_if.asm                 lane,
    input  logic [7:0]               ram_rdata_i,

    output logic [mem_pkg::XLEN-1:0] fetch_rdata_o,
    output logic                     fetch_valid_o,
    output logic [mem_pkg::XLEN-1:0] data_rdata_o,
    output logic                     data_valid_o,

    output logic                     done_o,
    output mem_pkg::port_e           done_port_o
);

    // tags delayed to line up with ram read data
    logic                     d_valid;
    logic                     d_last;
    mem_pkg::port_e           d_port;
    mem_pkg::access_size_e    d_size;
    logic [1:0]               d_lane;
    logic                     d_we;

    logic [mem_pkg::XLEN-1:0] gather_q;
    logic [mem_pkg::XLEN-1:0] merged_word;
    logic [mem_pkg::XLEN-1:0] size_mask;
    logic                     read_done;
    logic                     write_done;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= lane.valid;
        end
        d_last <= lane.last;
        d_port <= lane.port;
        d_size <= lane.size;
        d_lane <= lane.lane;
        d_we   <= lane.we;
    end

    always_comb begin
        merged_word = gather_q;
        merged_word[{d_lane, 3'b000} +: 8] = ram_rdata_i;
    end

    // zero the bytes above a short load
    always_comb begin
        case (d_size)
            mem_pkg::SIZE_BYTE: size_mask = 32'h0000_00ff;
            mem_pkg::SIZE_HALF: size_mask = 32'h0000_ffff;
            default:            size_mask = 32'hffff_ffff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (d_valid && !d_we) begin
            gather_q <= merged_word;
        end
    end

    assign read_done  = d_valid && d_last && !d_we;
    // stores finish on the undelayed tag
    assign write_done = lane.valid && lane.last && lane.we;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_valid_o <= 1'b0;
            data_valid_o  <= 1'b0;
            done_o        <= 1'b0;
            done_port_o   <= mem_pkg::PORT_FETCH;
            fetch_rdata_o <= '0;
            data_rdata_o  <= '0;
        end else begin
            fetch_valid_o <= (read_done && d_port == mem_pkg::PORT_FETCH) ||
                             (write_done && lane.port == mem_pkg::PORT_FETCH);
            data_valid_o  <= (read_done && d_port == mem_pkg::PORT_DATA) ||
                             (write_done && lane.port == mem_pkg::PORT_DATA);
            done_o        <= read_done || write_done;
            if (read_done) begin
                done_port_o <= d_port;
            end else if (write_done) begin
                done_port_o <= lane.port;
            end
            if (read_done && d_port == mem_pkg::PORT_FETCH) begin
                fetch_rdata_o <= merged_word & size_mask;
            end
            if (read_done && d_port == mem_pkg::PORT_DATA) begin
                data_rdata_o <= merged_word & size_mask;
            end
        end
    end

    a_one_valid: assert property (@(posedge clk) disable iff (rst_i)
        !(fetch_valid_o && data_valid_o));

endmodule

//--- byte_sequencer.sv
// byte transfer sequencer
`timescale 1ns/1ps

module byte_sequencer #(
    parameter int ADDR_W = mem_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              rst_i,

    mem_op_if.seq             op,
    byte_lane_if.seq          lane,

    output logic [ADDR_W-1:0] ram_addr_o,
    output logic [7:0]        ram_wdata_o,
    output logic              ram_we_o
);

    logic                     active;
    logic [1:0]               cnt;
    logic                     last_byte;
    logic                     take_op;

    // current access
    mem_pkg::port_e           cur_port;
    logic                     cur_we;
    logic [ADDR_W-1:0]        cur_addr;
    logic [mem_pkg::XLEN-1:0] cur_wdata;
    mem_pkg::access_size_e    cur_size;

    // idle only, so one free cycle between runs
    assign op.ready = !active;
    assign take_op  = op.valid && !active;

    assign last_byte = ({1'b0, cnt} == mem_pkg::byte_count(cur_size) - 3'd1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            active <= 1'b0;
            cnt    <= 2'd0;
        end else if (take_op) begin
            active <= 1'b1;
            cnt    <= 2'd0;
        end else if (active) begin
            if (last_byte) begin
                active <= 1'b0;
                cnt    <= 2'd0;
            end else begin
                cnt <= cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_op) begin
            cur_port  <= op.port;
            cur_we    <= op.we;
            cur_addr  <= op.addr;
            cur_wdata <= op.wdata;
            cur_size  <= op.size;
        end
    end

    // little-endian, byte k goes to addr + k
    assign ram_addr_o  = cur_addr + ADDR_W'(cnt);
    assign ram_wdata_o = cur_wdata[{cnt, 3'b000} +: 8];
    assign ram_we_o    = active && cur_we;

    // tag for every byte on the bus
    assign lane.valid = active;
    assign lane.last  = active && last_byte;
    assign lane.port  = cur_port;
    assign lane.size  = cur_size;
    assign lane.lane  = cnt;
    assign lane.we    = cur_we;

    // fetch accesses come out of the arbiter as reads
    a_no_fetch_write: assert property (@(posedge clk) disable iff (rst_i)
        ram_we_o |-> cur_port == mem_pkg::PORT_DATA);

endmodule

//--- mem_arbiter.sv
// requester arbitration stage
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int ADDR_W = mem_pkg::ADDR_W
) (
    input  logic                      clk,
    input  logic                      rst_i,

    input  logic                      data_req_i,
    input  logic                      data_we_i,
    input  logic [ADDR_W-1:0]         data_addr_i,
    input  logic [mem_pkg::XLEN-1:0]  data_wdata_i,
    input  mem_pkg::access_size_e     data_size_i,

    input  logic                      fetch_req_i,
    input  logic [ADDR_W-1:0]         fetch_addr_i,

    output logic                      data_busy_o,
    output logic                      fetch_busy_o,

    input  mem_pkg::port_e            done_port_i,
    input  logic                      done_i,

    mem_op_if.arb                     op
);

    logic slot_valid;
    logic data_inprog;
    logic fetch_inprog;
    logic slot_free;
    logic take_data;
    logic take_fetch;

    // slot frees up in the same cycle the sequencer takes it
    assign slot_free  = !slot_valid || op.ready;
    assign take_data  = slot_free && data_req_i && !data_inprog;
    assign take_fetch = slot_free && fetch_req_i && !fetch_inprog && !take_data;

    assign op.valid     = slot_valid;
    assign data_busy_o  = data_inprog;
    assign fetch_busy_o = fetch_inprog;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            slot_valid   <= 1'b0;
            data_inprog  <= 1'b0;
            fetch_inprog <= 1'b0;
        end else begin
            if (take_data || take_fetch) begin
                slot_valid <= 1'b1;
            end else if (op.ready) begin
                slot_valid <= 1'b0;
            end

            if (take_data) begin
                data_inprog <= 1'b1;
            end else if (done_i && done_port_i == mem_pkg::PORT_DATA) begin
                data_inprog <= 1'b0;
            end

            if (take_fetch) begin
                fetch_inprog <= 1'b1;
            end else if (done_i && done_port_i == mem_pkg::PORT_FETCH) begin
                fetch_inprog <= 1'b0;
            end
        end
    end

    // held access, fetch is always a word read
    always_ff @(posedge clk) begin
        if (take_data) begin
            op.port  <= mem_pkg::PORT_DATA;
            op.we    <= data_we_i;
            op.addr  <= data_addr_i;
            op.wdata <= data_wdata_i;
            op.size  <= data_size_i;
        end else if (take_fetch) begin
            op.port  <= mem_pkg::PORT_FETCH;
            op.we    <= 1'b0;
            op.addr  <= fetch_addr_i;
            op.wdata <= '0;
            op.size  <= mem_pkg::SIZE_WORD;
        end
    end

    a_op_stable: assert property (@(posedge clk) disable iff (rst_i)
        op.valid && !op.ready |=> $stable({op.port, op.we, op.addr, op.wdata, op.size}));

endmodule

//--- byte_lane_if.sv
// per-byte tag channel
`timescale 1ns/1ps

interface byte_lane_if;

    logic                  valid;
    logic                  last;
    mem_pkg::port_e        port;
    mem_pkg::access_size_e size;
    logic [1:0]            lane;
    // store run, no read data follows
    logic                  we;

    // no back-pressure, assembler takes one byte per cycle
    modport seq (
        output valid, last, port, size, lane, we
    );

    modport asm (
        input  valid, last, port, size, lane, we
    );

endinterface

//--- mem_op_if.sv
// accepted access channel
`timescale 1ns/1ps

interface mem_op_if #(
    parameter int ADDR_W = mem_pkg::ADDR_W
);

    logic                         valid;
    logic                         ready;
    mem_pkg::port_e               port;
    logic                         we;
    logic [ADDR_W-1:0]            addr;
    logic [mem_pkg::XLEN-1:0]     wdata;
    mem_pkg::access_size_e        size;

    // arbiter side owns the payload
    modport arb (
        output valid, port, we, addr, wdata, size,
        input  ready
    );

    modport seq (
        input  valid, port, we, addr, wdata, size,
        output ready
    );

endinterface

//--- mem_pkg.sv
// memory controller definitions
package mem_pkg;

    // default address width, overridden through module parameters
    localparam int ADDR_W = 32;

    // word width fixed by the instruction set
    localparam int XLEN = 32;

    // data access width
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // owner of an access
    typedef enum logic {
        PORT_FETCH = 1'b0,
        PORT_DATA  = 1'b1
    } port_e;

    // bytes moved for one access
    function automatic logic [2:0] byte_count(access_size_e size);
        logic [2:0] count;
        case (size)
            SIZE_BYTE: count = 3'd1;
            SIZE_HALF: count = 3'd2;
            default:   count = 3'd4;
        endcase
        return count;
    endfunction

endpackage
